/* sources.f */
+incdir+verilog
verilog/corePkg.sv
verilog/regFile.sv
verilog/immExtend.sv
verilog/instrDecoder.sv
verilog/decodeStage.sv
verilog/executeStage.sv
verilog/resultStage.sv
verilog/coreTop.sv
dv/tbClock.sv
dv/tbCoreTop.sv

/* run.sh */
#!/bin/sh
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f sources.f --top-module tbCoreTop -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation run returned status $status"
  exit 1
fi

if grep -q "Simulation passed" "$LOG"; then
  exit 0
else
  exit 1
fi

/* dv/tbCoreTop.sv */
`include "coreMacros.svh"

module tbCoreTop;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PROG_LEN  = 60;
  localparam int MEM_WORDS = PROG_LEN + 8;
  localparam int TIMEOUT   = 3000;
  localparam logic [31:0] SEED = 32'd98076;
  localparam logic [31:0] NOP  = 32'h0000_0013;

  // Own instruction kinds for the reference model
  localparam int K_OP = 0, K_OPI = 1, K_LUI = 2, K_BEQ = 3, K_BNE = 4, K_JAL = 5;

  logic clk, rst, stall;
  logic [`XLEN-1:0] instrF, pcF, pcPlus4F;
  logic pcSrcE, regWriteW;
  logic [`XLEN-1:0] pcTargetE, resultW;
  logic [`REG_ADDR_W-1:0] rdW;

  logic [31:0] lfsr = SEED;
  logic [31:0] imem [0:MEM_WORDS-1];
  int kindA [0:PROG_LEN-1];
  int fnA [0:PROG_LEN-1];  // 0 add 1 sub 2 and 3 or 4 xor 5 slt
  int rdA [0:PROG_LEN-1];
  int rs1A [0:PROG_LEN-1];
  int rs2A [0:PROG_LEN-1];
  int immA [0:PROG_LEN-1];

  logic [4:0] expRd [$];
  logic [31:0] expVal [$];
  logic [31:0] expTarget [$];

  logic [31:0] pc;
  logic decodeHeld;  // Fetch word not taken at the last rising edge
  int errors = 0;
  int checks = 0;
  int outCycles = 0;

  tbClock clkGen (.clk(clk), .rst(rst));

  coreTop UUT (
    .clk(clk), .rst(rst), .stall(stall), .instrF(instrF), .pcF(pcF),
    .pcPlus4F(pcPlus4F), .pcSrcE(pcSrcE), .pcTargetE(pcTargetE),
    .regWriteW(regWriteW), .rdW(rdW), .resultW(resultW)
  );

  always @(posedge clk) begin
    decodeHeld <= rst || stall || pcSrcE;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] randBits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic int fnFunct3(int fn);
    case (fn)
      2: return 7;
      3: return 6;
      4: return 4;
      5: return 2;
      default: return 0;
    endcase
  endfunction

  function automatic logic [31:0] encode(int idx);
    logic [31:0] imm;
    logic [4:0] rd, rs1, rs2;
    logic [2:0] f3;
    imm = immA[idx];
    rd = rdA[idx];
    rs1 = rs1A[idx];
    rs2 = rs2A[idx];
    f3 = fnFunct3(fnA[idx]);
    case (kindA[idx])
      K_OP: return {(fnA[idx] == 1) ? 7'b0100000 : 7'b0, rs2, rs1, f3, rd, 7'b0110011};
      K_OPI: return {imm[11:0], rs1, f3, rd, 7'b0010011};
      K_LUI: return {imm[19:0], rd, 7'b0110111};
      K_BEQ, K_BNE: return {imm[12], imm[10:5], rs2, rs1, 2'b00,
                            (kindA[idx] == K_BNE), imm[4:1], imm[11], 7'b1100011};
      default: return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endcase
  endfunction

  task automatic setInstr(int idx, int kind, int fn, int rd, int rs1, int rs2, int imm);
    kindA[idx] = kind;
    fnA[idx] = fn;
    rdA[idx] = rd;
    rs1A[idx] = rs1;
    rs2A[idx] = rs2;
    immA[idx] = imm;
  endtask

  task automatic buildProgram();
    logic [31:0] v;
    int kind, fn, skip, imm;
    for (int i = 0; i < MEM_WORDS; i++) imem[i] = NOP;
    setInstr(0, K_OPI, 0, 1, 0, 0, 5);   // Back-to-back chain
    setInstr(1, K_OPI, 0, 2, 1, 0, 3);
    setInstr(2, K_OP, 0, 3, 1, 2, 0);    // Distance two on x1
    setInstr(3, K_OPI, 0, 0, 3, 0, 7);   // Write aimed at x0
    setInstr(4, K_OP, 0, 4, 0, 3, 0);    // Reads x0 right after
    for (int i = 5; i < PROG_LEN; i++) begin
      v = randBits(3);
      kind = (v < 2) ? K_OP : (v < 4) ? K_OPI : (v == 4) ? K_LUI :
             (v == 5) ? K_BEQ : (v == 6) ? K_BNE : K_JAL;
      fn = randBits(3);
      if (fn > 5 || (kind == K_OPI && fn == 1)) fn = 0;
      v = randBits(6);
      imm = v[5] ? int'(v) - 64 : int'(v);
      if (kind == K_LUI) imm = randBits(8);
      if (kind >= K_BEQ) begin
        skip = 2 + randBits(1) + randBits(1);  // Forward only
        if (i + skip > PROG_LEN) skip = PROG_LEN - i;
        imm = skip * 4;
      end
      setInstr(i, kind, fn, randBits(3), randBits(3), randBits(3), imm);
    end
    for (int i = 0; i < PROG_LEN; i++) imem[i] = encode(i);
  endtask

  // Architectural model in program order
  task automatic runModel();
    logic [31:0] regs [0:31];
    logic [31:0] a, b, val;
    int i;
    logic wr;
    for (int r = 0; r < 32; r++) regs[r] = '0;
    i = 0;
    while (i < PROG_LEN) begin
      a = regs[rs1A[i]];
      b = (kindA[i] == K_OP) ? regs[rs2A[i]] : immA[i];
      wr = 1'b1;
      case (kindA[i])
        K_LUI: val = immA[i] << 12;
        K_JAL: val = i * 4 + 4;
        K_BEQ, K_BNE: wr = 1'b0;
        default: begin
          case (fnA[i])
            1: val = a - b;
            2: val = a & b;
            3: val = a | b;
            4: val = a ^ b;
            5: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: val = a + b;
          endcase
        end
      endcase
      if (wr && rdA[i] != 0) begin
        regs[rdA[i]] = val;
        expRd.push_back(rdA[i]);
        expVal.push_back(val);
      end
      if (kindA[i] == K_JAL || (kindA[i] == K_BEQ && regs[rs1A[i]] == regs[rs2A[i]]) ||
          (kindA[i] == K_BNE && regs[rs1A[i]] != regs[rs2A[i]])) begin
        expTarget.push_back(i * 4 + immA[i]);
        i = i + immA[i] / 4;  // Younger instructions skipped
      end else begin
        i++;
      end
    end
  endtask

  function automatic logic [31:0] fetchWord(logic [31:0] addr);
    if ((addr >> 2) < MEM_WORDS) return imem[addr >> 2];
    return NOP;
  endfunction

  task automatic checkOutputs();
    logic [4:0] rdExp;
    logic [31:0] valExp;
    outCycles = rst ? 0 : outCycles + 1;
    // First instruction reaches write-back no earlier than the fourth falling edge
    assert (!((rst || outCycles <= 3) && (regWriteW || pcSrcE)))
    else begin
      errors++;
      $display("Write-back or redirect active right after reset at %0t", $time);
    end
    if (regWriteW && rdW != 0) begin
      checks++;
      assert (expRd.size() > 0) else begin
        errors++;
        $display("Unexpected write-back to x%0d at %0t", rdW, $time);
      end
      if (expRd.size() > 0) begin
        rdExp = expRd.pop_front();
        valExp = expVal.pop_front();
        assert (rdW == rdExp) else begin
          errors++;
          $display("Fail time=%0t rdW expected=%0d got=%0d", $time, rdExp, rdW);
        end
        assert (resultW == valExp) else begin
          errors++;
          $display("Fail time=%0t resultW expected=%h got=%h", $time, valExp, resultW);
        end
      end
    end
    if (pcSrcE) begin
      checks++;
      assert (expTarget.size() > 0) else begin
        errors++;
        $display("Redirect to %h that the model never took at %0t", pcTargetE, $time);
      end
      if (expTarget.size() > 0) begin
        valExp = expTarget.pop_front();
        assert (pcTargetE == valExp) else begin
          errors++;
          $display("Fail time=%0t pcTargetE expected=%h got=%h", $time, valExp, pcTargetE);
        end
      end
    end
  endtask

  task automatic driveFetch(logic randomStall);
    if (pcSrcE) pc = pcTargetE;
    else if (!decodeHeld) pc = pc + 4;
    stall = randomStall && !rst && (randBits(2) == 2'b11);
    instrF = fetchWord(pc);
    pcF = pc;
    pcPlus4F = pc + 4;
  endtask

  task automatic stepCycle(logic randomStall);
    @(negedge clk);
    checkOutputs();
    driveFetch(randomStall);
  endtask

  initial begin
    int cycles;
    stall = 1'b0;
    pc = `RESET_PC;
    instrF = NOP;
    pcF = `RESET_PC;
    pcPlus4F = `RESET_PC + 4;
    buildProgram();
    runModel();
    cycles = 0;
    while (rst !== 1'b0 && cycles < 100) begin
      stepCycle(1'b0);
      cycles++;
    end
    if (rst !== 1'b0) begin
      errors++;
      $display("Reset never released");
    end
    cycles = 0;
    while (!((pc >> 2) > PROG_LEN && expRd.size() == 0 && expTarget.size() == 0) &&
           cycles < TIMEOUT) begin
      stepCycle(1'b1);
      cycles++;
    end
    if (cycles >= TIMEOUT) begin
      errors++;
      $display("Timed out with %0d write-backs still expected", expRd.size());
    end
    cycles = 0;
    while (cycles < 8) begin  // Nothing extra may come out
      stepCycle(1'b0);
      cycles++;
    end
    $display("Errors: %0d, checks: %0d, left in queue: %0d", errors, checks, expRd.size());
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* dv/tbClock.sv */
module tbClock (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (10) @(posedge clk);
    rst <= 1'b0;  // Released on an edge, seen cleanly by all flops
  end

endmodule

/* verilog/coreTop.sv */
`include "coreMacros.svh"

module coreTop (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall,
  input  logic [`XLEN-1:0]       instrF,
  input  logic [`XLEN-1:0]       pcF,
  input  logic [`XLEN-1:0]       pcPlus4F,
  output logic                   pcSrcE,
  output logic [`XLEN-1:0]       pcTargetE,
  output logic                   regWriteW,
  output logic [`REG_ADDR_W-1:0] rdW,
  output logic [`XLEN-1:0]       resultW
);
  import corePkg::*;

  // Decode to execute
  logic [`XLEN-1:0]       rd1D, rd2D, immExtD, pcD, pcPlus4D;
  logic [`REG_ADDR_W-1:0] rdD, rs1D, rs2D;
  logic                   regWriteD, branchD, branchNeD, jumpD, aluSrcD;
  aluOpT                  aluOpD;
  resultSrcT              resultSrcD;

  // Execute to result
  logic                   regWriteE;
  logic [`REG_ADDR_W-1:0] rdE;
  logic [`XLEN-1:0]       aluResultE, pcPlus4E;
  resultSrcT              resultSrcE;

  decodeStage decode (.*, .flush(pcSrcE));  // Redirect clears decode

  executeStage execute (.*);

  resultStage result (.*);

endmodule

/* verilog/resultStage.sv */
`include "coreMacros.svh"

module resultStage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   regWriteE,
  input  logic [`REG_ADDR_W-1:0] rdE,
  input  logic [`XLEN-1:0]       aluResultE,
  input  logic [`XLEN-1:0]       pcPlus4E,
  input  corePkg::resultSrcT     resultSrcE,
  output logic                   regWriteW,
  output logic [`REG_ADDR_W-1:0] rdW,
  output logic [`XLEN-1:0]       resultW
);
  import corePkg::*;

  logic [`XLEN-1:0] aluResultW;
  logic [`XLEN-1:0] pcPlus4W;
  resultSrcT        resultSrcW;

  always_ff @(posedge clk) begin
    if (rst) begin
      regWriteW <= 1'b0;
    end else begin
      regWriteW <= regWriteE;
    end
  end

  always_ff @(posedge clk) begin
    rdW        <= rdE;
    aluResultW <= aluResultE;
    pcPlus4W   <= pcPlus4E;
    resultSrcW <= resultSrcE;
  end

  assign resultW = (resultSrcW == RES_PC4) ? pcPlus4W : aluResultW;  // jal links pc+4

endmodule

/* verilog/executeStage.sv */
`include "coreMacros.svh"

module executeStage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall,
  input  logic [`XLEN-1:0]       rd1D,
  input  logic [`XLEN-1:0]       rd2D,
  input  logic [`XLEN-1:0]       immExtD,
  input  logic [`REG_ADDR_W-1:0] rdD,
  input  logic [`REG_ADDR_W-1:0] rs1D,
  input  logic [`REG_ADDR_W-1:0] rs2D,
  input  logic                   regWriteD,
  input  logic                   branchD,
  input  logic                   branchNeD,
  input  logic                   jumpD,
  input  logic                   aluSrcD,
  input  corePkg::aluOpT         aluOpD,
  input  corePkg::resultSrcT     resultSrcD,
  input  logic [`XLEN-1:0]       pcD,
  input  logic [`XLEN-1:0]       pcPlus4D,
  input  logic                   regWriteW,
  input  logic [`REG_ADDR_W-1:0] rdW,
  input  logic [`XLEN-1:0]       resultW,
  output logic                   pcSrcE,
  output logic [`XLEN-1:0]       pcTargetE,
  output logic                   regWriteE,
  output logic [`REG_ADDR_W-1:0] rdE,
  output logic [`XLEN-1:0]       aluResultE,
  output logic [`XLEN-1:0]       pcPlus4E,
  output corePkg::resultSrcT     resultSrcE
);
  import corePkg::*;

  logic                   branchE, branchNeE, jumpE, aluSrcE;
  aluOpT                  aluOpE;
  logic [`XLEN-1:0]       rd1E, rd2E, immExtE, pcE;
  logic [`REG_ADDR_W-1:0] rs1E, rs2E;
  logic [`XLEN-1:0]       srcAE, writeDataE, srcBE;
  logic                   zeroE;

  // Control part of the decode/execute register
  always_ff @(posedge clk) begin
    if (rst || stall || pcSrcE) begin  // Load a bubble
      regWriteE <= 1'b0;
      branchE   <= 1'b0;
      jumpE     <= 1'b0;
    end else begin
      regWriteE <= regWriteD;
      branchE   <= branchD;
      jumpE     <= jumpD;
    end
  end

  always_ff @(posedge clk) begin
    branchNeE  <= branchNeD;
    aluSrcE    <= aluSrcD;
    aluOpE     <= aluOpD;
    resultSrcE <= resultSrcD;
    rd1E       <= rd1D;
    rd2E       <= rd2D;
    immExtE    <= immExtD;
    rdE        <= rdD;
    rs1E       <= rs1D;
    rs2E       <= rs2D;
    pcE        <= pcD;
    pcPlus4E   <= pcPlus4D;
  end

  // Forward from write-back, x0 never forwarded
  assign srcAE = (regWriteW && (rdW != '0) && (rdW == rs1E)) ? resultW : rd1E;
  assign writeDataE = (regWriteW && (rdW != '0) && (rdW == rs2E)) ? resultW : rd2E;
  assign srcBE = aluSrcE ? immExtE : writeDataE;

  always_comb begin
    case (aluOpE)
      ALU_ADD:    aluResultE = srcAE + srcBE;
      ALU_SUB:    aluResultE = srcAE - srcBE;
      ALU_AND:    aluResultE = srcAE & srcBE;
      ALU_OR:     aluResultE = srcAE | srcBE;
      ALU_XOR:    aluResultE = srcAE ^ srcBE;
      ALU_SLT:    aluResultE = {{(`XLEN-1){1'b0}}, $signed(srcAE) < $signed(srcBE)};
      ALU_PASS_B: aluResultE = srcBE;
      default:    aluResultE = srcAE + srcBE;
    endcase
  end

  assign zeroE     = (aluResultE == '0);
  assign pcSrcE    = jumpE || (branchE && (zeroE != branchNeE));  // bne inverts
  assign pcTargetE = pcE + immExtE;

  // Branch equality needs rs1 - rs2 in the ALU, jal links pc+4
  redirectSetupA: assert property (
    @(posedge clk) disable iff (rst) (branchE || jumpE) |->
      (jumpE ? (resultSrcE == RES_PC4) : ((aluOpE == ALU_SUB) && !aluSrcE))
  ) else $error("executeStage: branch or jal reached execute with wrong controls");

endmodule

/* verilog/decodeStage.sv */
`include "coreMacros.svh"

module decodeStage (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   stall,
  input  logic                   flush,
  input  logic [`XLEN-1:0]       instrF,
  input  logic [`XLEN-1:0]       pcF,
  input  logic [`XLEN-1:0]       pcPlus4F,
  input  logic                   regWriteW,
  input  logic [`REG_ADDR_W-1:0] rdW,
  input  logic [`XLEN-1:0]       resultW,
  output logic [`XLEN-1:0]       rd1D,
  output logic [`XLEN-1:0]       rd2D,
  output logic [`XLEN-1:0]       immExtD,
  output logic [`REG_ADDR_W-1:0] rdD,
  output logic [`REG_ADDR_W-1:0] rs1D,
  output logic [`REG_ADDR_W-1:0] rs2D,
  output logic                   regWriteD,
  output logic                   branchD,
  output logic                   branchNeD,
  output logic                   jumpD,
  output logic                   aluSrcD,
  output corePkg::aluOpT         aluOpD,
  output corePkg::resultSrcT     resultSrcD,
  output logic [`XLEN-1:0]       pcD,
  output logic [`XLEN-1:0]       pcPlus4D
);
  import corePkg::*;

  logic [`XLEN-1:0] instrD;
  logic             validD;  // Low for a bubble
  logic             regWriteDec, branchDec, jumpDec;
  logic             illegalD;
  immSrcT           immSrcD;

  // Fetch/decode register, flush wins over stall
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      instrD   <= `NOP_INSTR;
      pcD      <= `RESET_PC;
      pcPlus4D <= `RESET_PC + 32'd4;
      validD   <= 1'b0;
    end else if (!stall) begin
      instrD   <= instrF;
      pcD      <= pcF;
      pcPlus4D <= pcPlus4F;
      validD   <= 1'b1;
    end
  end

  assign rdD  = instrD[11:7];
  assign rs1D = instrD[19:15];
  assign rs2D = instrD[24:20];

  instrDecoder dec (
    .instr(instrD), .regWrite(regWriteDec), .branch(branchDec), .branchNe(branchNeD),
    .jump(jumpDec), .aluSrc(aluSrcD), .immSrc(immSrcD), .aluOp(aluOpD),
    .resultSrc(resultSrcD), .illegal(illegalD)
  );

  // A bubble carries no write and no redirect
  assign regWriteD = regWriteDec && validD;
  assign branchD   = branchDec && validD;
  assign jumpD     = jumpDec && validD;

  regFile rf (
    .clk(clk), .we3(regWriteW), .a1(rs1D), .a2(rs2D), .a3(rdW),
    .wd3(resultW), .rd1(rd1D), .rd2(rd2D)
  );

  immExtend ext (.instr(instrD), .immSrc(immSrcD), .immExt(immExtD));

  illegalNeverValidA: assert property (
    @(posedge clk) disable iff (rst) validD |-> !illegalD
  ) else $error("decodeStage: unsupported instruction %h at pc %h", instrD, pcD);

endmodule

/* verilog/instrDecoder.sv */
`include "coreMacros.svh"

module instrDecoder (
  input  logic [`XLEN-1:0]   instr,
  output logic               regWrite,
  output logic               branch,
  output logic               branchNe,
  output logic               jump,
  output logic               aluSrc,
  output corePkg::immSrcT    immSrc,
  output corePkg::aluOpT     aluOp,
  output corePkg::resultSrcT resultSrc,
  output logic               illegal
);
  import corePkg::*;

  opcodeT     opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  aluOpT      aluFn;  // Op from the funct fields
  logic       fnBad;  // Unsupported funct combination

  assign opcode = opcodeT'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // ALU decoder, shared by OP and OP_IMM
  always_comb begin
    fnBad = 1'b0;
    case (funct3)
      3'b000:  aluFn = ((opcode == OP) && funct7[5]) ? ALU_SUB : ALU_ADD;
      3'b010:  aluFn = ALU_SLT;
      3'b100:  aluFn = ALU_XOR;
      3'b110:  aluFn = ALU_OR;
      3'b111:  aluFn = ALU_AND;
      default: begin  // Shifts and sltu are not built
        aluFn = ALU_ADD;
        fnBad = 1'b1;
      end
    endcase
    // Only sub may set funct7 bit 5 in an OP instruction
    if ((opcode == OP) && (funct7 != 7'b0000000) &&
        !((funct7 == 7'b0100000) && (funct3 == 3'b000))) begin
      fnBad = 1'b1;
    end
  end

  // Main decoder
  always_comb begin
    regWrite  = 1'b0;
    branch    = 1'b0;
    branchNe  = 1'b0;
    jump      = 1'b0;
    aluSrc    = 1'b0;
    immSrc    = IMM_I;
    aluOp     = ALU_ADD;
    resultSrc = RES_ALU;
    illegal   = 1'b0;
    case (opcode)
      OP: begin
        regWrite = !fnBad;
        aluOp    = aluFn;
        illegal  = fnBad;
      end
      OP_IMM: begin
        regWrite = !fnBad;
        aluSrc   = 1'b1;
        aluOp    = aluFn;
        illegal  = fnBad;
      end
      LUI: begin
        regWrite = 1'b1;
        aluSrc   = 1'b1;
        immSrc   = IMM_U;
        aluOp    = ALU_PASS_B;
      end
      BRANCH: begin
        branch   = (funct3[2:1] == 2'b00);  // beq or bne only
        branchNe = funct3[0];
        immSrc   = IMM_B;
        aluOp    = ALU_SUB;  // Zero flag gives equality
        illegal  = (funct3[2:1] != 2'b00);
      end
      JAL: begin
        regWrite  = 1'b1;
        jump      = 1'b1;
        immSrc    = IMM_J;
        resultSrc = RES_PC4;
      end
      default: illegal = 1'b1;
    endcase
  end

endmodule

/* verilog/immExtend.sv */
`include "coreMacros.svh"

module immExtend (
  input  logic [`XLEN-1:0] instr,
  input  corePkg::immSrcT  immSrc,
  output logic [`XLEN-1:0] immExt
);
  import corePkg::*;

  always_comb begin
    case (immSrc)
      IMM_I: begin
        immExt = {{20{instr[31]}}, instr[31:20]};
      end
      IMM_B: begin  // Branch offset, bit 0 implied
        immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      IMM_J: begin  // Jump offset, scrambled field order
        immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      IMM_U: begin
        immExt = {instr[31:12], 12'b0};  // Upper 20 bits, left aligned
      end
      default: begin
        immExt = '0;
      end
    endcase
  end

endmodule

/* verilog/regFile.sv */
`include "coreMacros.svh"

module regFile (
  input  logic                   clk,
  input  logic                   we3,
  input  logic [`REG_ADDR_W-1:0] a1,
  input  logic [`REG_ADDR_W-1:0] a2,
  input  logic [`REG_ADDR_W-1:0] a3,
  input  logic [`XLEN-1:0]       wd3,
  output logic [`XLEN-1:0]       rd1,
  output logic [`XLEN-1:0]       rd2
);

  logic [`XLEN-1:0] regs [(1 << `REG_ADDR_W)-1:0];

  // Falling edge write, so decode sees the value in the same cycle
  always_ff @(negedge clk) begin
    if (we3 && (a3 != '0)) begin
      regs[a3] <= wd3;
    end
  end

  assign rd1 = (a1 == '0) ? '0 : regs[a1];  // x0 hardwired
  assign rd2 = (a2 == '0) ? '0 : regs[a2];

  // The word written at the falling edge is on the read ports by the next rising edge,
  // and a write aimed at x0 still reads zero
  property writeReadBack;
    @(posedge clk) we3 |->
      ((a1 != a3) || (rd1 == ((a3 == '0) ? '0 : wd3))) &&
      ((a2 != a3) || (rd2 == ((a3 == '0) ? '0 : wd3)));
  endproperty

  writeReadBackA: assert property (writeReadBack)
    else $error("regFile: written value or x0 not seen on a read port");

endmodule

/* verilog/corePkg.sv */
package corePkg;

  // Major opcodes handled by this core
  typedef enum logic [6:0] {
    OP     = 7'b0110011,  // Register-register ALU
    OP_IMM = 7'b0010011,  // Register-immediate ALU
    LUI    = 7'b0110111,
    BRANCH = 7'b1100011,  // beq, bne
    JAL    = 7'b1101111
  } opcodeT;

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,  // Signed compare
    ALU_PASS_B = 3'd6   // For lui
  } aluOpT;

  typedef enum logic [1:0] {
    IMM_I = 2'd0,
    IMM_B = 2'd1,
    IMM_J = 2'd2,
    IMM_U = 2'd3
  } immSrcT;

  typedef enum logic {
    RES_ALU = 1'b0,
    RES_PC4 = 1'b1  // Link value for jal
  } resultSrcT;

endpackage

/* verilog/coreMacros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Data and pc width
`define XLEN 32

// Register index width
`define REG_ADDR_W 5

// Pc held by a cleared pipeline register
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif
